/* common/ccu_pkg.sv */
// Configuration control unit
// Shared widths, opcodes and record types
package ccu_pkg;

    // ====================
    // Widths
    // ====================
    localparam int ISA_WIDTH    = 256;
    localparam int ADDR_WIDTH   = 16;
    localparam int OPCODE_WIDTH = 8;
    localparam int LAYER_WIDTH  = 20;

    localparam int ACT_WIDTH    = 8;    // Shift and zero point
    localparam int MODE_WIDTH   = 2;
    localparam int CHN_WIDTH    = 12;
    localparam int SCALE_WIDTH  = 20;
    localparam int IDX_WIDTH    = 16;   // Point count
    localparam int KSIZE_WIDTH  = 6;

    // One channel+kernel pair per pooling core in word 1
    localparam int POL_PAIR_BITS = CHN_WIDTH + KSIZE_WIDTH;

    // ====================
    // Opcodes / requesters
    // ====================
    // Opcode doubles as requester index, 0 is highest priority
    localparam int OP_CCU  = 0;
    localparam int OP_SYA  = 1;
    localparam int OP_POL  = 2;
    localparam int NUM_REQ = 3;

    // Matching words per configuration
    localparam int WORDS_CCU = 1;
    localparam int WORDS_SYA = 2;
    localparam int WORDS_POL = 2;

    // ====================
    // Types
    // ====================
    typedef logic [ISA_WIDTH-1:0]  isa_word_t;
    typedef logic [ADDR_WIDTH-1:0] isa_addr_t;
    typedef logic [1:0]            req_idx_t;

    // Systolic array record, lowest field first in the word
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]  ofm_base;       // Word 1
        logic [ADDR_WIDTH-1:0]  wgt_base;
        logic [ADDR_WIDTH-1:0]  act_base;
        logic [SCALE_WIDTH-1:0] scale;          // Word 0
        logic [CHN_WIDTH-1:0]   chn;
        logic                   phase_shift;
        logic [MODE_WIDTH-1:0]  mode;
        logic [ACT_WIDTH-1:0]   zp;
        logic [ACT_WIDTH-1:0]   shift;
    } sya_cfg_t;

    // One pooling core
    typedef struct packed {
        logic [KSIZE_WIDTH-1:0] ksize;
        logic [CHN_WIDTH-1:0]   chn;
        logic [IDX_WIDTH-1:0]   nip;
    } pol_core_cfg_t;

endpackage

/* decode/isa_decode.sv */
// Instruction decode and configuration records
`timescale 1ns/1ps

module isa_decode #(
    parameter int POOL_CORE = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  ccu_pkg::isa_word_t                     dat_i,
    input  logic                                   dat_vld_i,
    input  ccu_pkg::isa_addr_t                     tag_i,
    input  logic                                   tag_empty_i,
    input  logic                                   op_start_i,
    input  ccu_pkg::req_idx_t                      grant_i,
    input  logic                                   idle_i,
    input  logic                                   sya_cfg_rdy_i,
    input  logic                                   pol_cfg_rdy_i,
    output logic                                   dat_rdy_o,
    output logic                                   pop_o,
    output logic                                   op_done_o,
    output ccu_pkg::isa_addr_t                     next_addr_o,
    output logic                                   ccu_req_o,
    output logic                                   sya_req_o,
    output logic                                   pol_req_o,
    output logic                                   layers_met_o,
    output logic                                   sya_cfg_vld_o,
    output ccu_pkg::sya_cfg_t                      sya_cfg_o,
    output logic                                   pol_cfg_vld_o,
    output ccu_pkg::pol_core_cfg_t [POOL_CORE-1:0] pol_cfg_o
);
    import ccu_pkg::*;

    localparam int SYA_W0_BITS = 2 * ACT_WIDTH + MODE_WIDTH + 1 + CHN_WIDTH + SCALE_WIDTH;

    logic                   open_q;
    logic [1:0]             wcnt_q, last_idx;
    logic                   hit;
    logic [LAYER_WIDTH-1:0] layer_num_q, sya_hs_cnt_q;
    logic                   ccu_req_q, sya_vld_q, pol_vld_q;
    sya_cfg_t               sya_q;
    pol_core_cfg_t [POOL_CORE-1:0] pol_q;

    // ====================
    // Word matching
    // ====================
    assign dat_rdy_o = !tag_empty_i;
    assign pop_o     = dat_vld_i && dat_rdy_o;    // Words outside a configuration are dropped
    assign hit       = pop_o && open_q && (dat_i[OPCODE_WIDTH-1:0] == OPCODE_WIDTH'(grant_i));

    always_comb begin
        case (grant_i)
            req_idx_t'(OP_SYA): last_idx = 2'(WORDS_SYA - 1);
            req_idx_t'(OP_POL): last_idx = 2'(WORDS_POL - 1);
            default:            last_idx = 2'(WORDS_CCU - 1);
        endcase
    end

    assign op_done_o   = hit && (wcnt_q == last_idx);
    assign next_addr_o = tag_i + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            open_q <= 1'b0;
            wcnt_q <= '0;
        end else if (op_start_i) begin
            open_q <= 1'b1;
            wcnt_q <= '0;
        end else if (op_done_o) begin
            open_q <= 1'b0;
        end else if (hit) begin
            wcnt_q <= wcnt_q + 1'b1;
        end
    end

    // ====================
    // Field decode
    // ====================
    always_ff @(posedge clk) begin
        if (hit && grant_i == req_idx_t'(OP_SYA)) begin
            if (wcnt_q == '0) begin
                {sya_q.scale, sya_q.chn, sya_q.phase_shift, sya_q.mode, sya_q.zp, sya_q.shift}
                    <= dat_i[OPCODE_WIDTH +: SYA_W0_BITS];
            end else begin
                {sya_q.ofm_base, sya_q.wgt_base, sya_q.act_base}
                    <= dat_i[OPCODE_WIDTH +: 3 * ADDR_WIDTH];
            end
        end
        if (hit && grant_i == req_idx_t'(OP_POL)) begin
            for (int c = 0; c < POOL_CORE; c++) begin
                if (wcnt_q == '0) begin
                    pol_q[c].nip <= dat_i[OPCODE_WIDTH + IDX_WIDTH * c +: IDX_WIDTH];
                end else begin
                    {pol_q[c].ksize, pol_q[c].chn}
                        <= dat_i[OPCODE_WIDTH + POL_PAIR_BITS * c +: POL_PAIR_BITS];
                end
            end
        end
    end

    // ====================
    // Valid, requests, layers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ccu_req_q    <= 1'b1;
            sya_vld_q    <= 1'b0;
            pol_vld_q    <= 1'b0;
            layer_num_q  <= '0;
            sya_hs_cnt_q <= '0;
        end else begin
            if (idle_i)
                ccu_req_q <= 1'b1;
            else if (op_done_o && grant_i == req_idx_t'(OP_CCU))
                ccu_req_q <= 1'b0;

            if (sya_vld_q && sya_cfg_rdy_i) sya_vld_q <= 1'b0;
            if (op_done_o && grant_i == req_idx_t'(OP_SYA)) sya_vld_q <= 1'b1;
            if (pol_vld_q && pol_cfg_rdy_i) pol_vld_q <= 1'b0;
            if (op_done_o && grant_i == req_idx_t'(OP_POL)) pol_vld_q <= 1'b1;

            if (idle_i) begin
                layer_num_q  <= '0;
                sya_hs_cnt_q <= '0;
            end else begin
                if (hit && grant_i == req_idx_t'(OP_CCU))
                    layer_num_q <= dat_i[OPCODE_WIDTH +: LAYER_WIDTH];
                if (sya_vld_q && sya_cfg_rdy_i)
                    sya_hs_cnt_q <= sya_hs_cnt_q + 1'b1;   // Accepted layers
            end
        end
    end

    assign ccu_req_o     = ccu_req_q;
    assign sya_req_o     = sya_cfg_rdy_i && !sya_vld_q;
    assign pol_req_o     = pol_cfg_rdy_i && !pol_vld_q;
    assign layers_met_o  = (layer_num_q != '0) && (sya_hs_cnt_q == layer_num_q);
    assign sya_cfg_vld_o = sya_vld_q;
    assign sya_cfg_o     = sya_q;
    assign pol_cfg_vld_o = pol_vld_q;
    assign pol_cfg_o     = pol_q;

endmodule

/* design/ccu_top.sv */
// Configuration control unit top
`timescale 1ns/1ps

module ccu_top #(
    parameter int POOL_CORE      = 2,
    parameter int ISA_FIFO_DEPTH = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   start_i,
    output logic                                   net_fnh_o,

    // Instruction RAM
    output ccu_pkg::isa_addr_t                     isa_rd_addr_o,
    output logic                                   isa_rd_addr_vld_o,
    input  logic                                   isa_rd_addr_rdy_i,
    input  ccu_pkg::isa_word_t                     isa_rd_dat_i,
    input  logic                                   isa_rd_dat_vld_i,
    output logic                                   isa_rd_dat_rdy_o,
    output ccu_pkg::isa_addr_t                     isa_min_addr_o,

    // Systolic array
    output logic                                   sya_rst_o,
    output logic                                   sya_cfg_vld_o,
    input  logic                                   sya_cfg_rdy_i,
    output ccu_pkg::sya_cfg_t                      sya_cfg_o,

    // Pooling cores
    output logic                                   pol_rst_o,
    output logic                                   pol_cfg_vld_o,
    input  logic                                   pol_cfg_rdy_i,
    output ccu_pkg::pol_core_cfg_t [POOL_CORE-1:0] pol_cfg_o
);
    import ccu_pkg::*;

    logic      fifo_full, fifo_empty;
    logic      push, pop;
    isa_addr_t pop_addr;
    logic      op_start, op_done;
    req_idx_t  grant;
    isa_addr_t next_addr;
    logic      idle;
    logic      ccu_req, sya_req, pol_req;
    logic      layers_met;

    // Engines held in reset while the unit is idle
    assign sya_rst_o = idle;
    assign pol_rst_o = idle;

    isa_fetch u_fetch (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_i           (start_i),
        .isa_rd_addr_rdy_i (isa_rd_addr_rdy_i),
        .fifo_full_i       (fifo_full),
        .fifo_empty_i      (fifo_empty),
        .ccu_req_i         (ccu_req),
        .sya_req_i         (sya_req),
        .pol_req_i         (pol_req),
        .op_done_i         (op_done),
        .next_addr_i       (next_addr),
        .layers_met_i      (layers_met),
        .isa_rd_addr_o     (isa_rd_addr_o),
        .isa_rd_addr_vld_o (isa_rd_addr_vld_o),
        .push_o            (push),
        .op_start_o        (op_start),
        .grant_o           (grant),
        .idle_o            (idle),
        .net_fnh_o         (net_fnh_o),
        .isa_min_addr_o    (isa_min_addr_o)
    );

    isa_tag_fifo #(
        .ISA_FIFO_DEPTH (ISA_FIFO_DEPTH)
    ) u_tag_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (push),
        .push_addr_i (isa_rd_addr_o),
        .pop_i       (pop),
        .pop_addr_o  (pop_addr),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

    isa_decode #(
        .POOL_CORE (POOL_CORE)
    ) u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .dat_i         (isa_rd_dat_i),
        .dat_vld_i     (isa_rd_dat_vld_i),
        .tag_i         (pop_addr),
        .tag_empty_i   (fifo_empty),
        .op_start_i    (op_start),
        .grant_i       (grant),
        .idle_i        (idle),
        .sya_cfg_rdy_i (sya_cfg_rdy_i),
        .pol_cfg_rdy_i (pol_cfg_rdy_i),
        .dat_rdy_o     (isa_rd_dat_rdy_o),
        .pop_o         (pop),
        .op_done_o     (op_done),
        .next_addr_o   (next_addr),
        .ccu_req_o     (ccu_req),
        .sya_req_o     (sya_req),
        .pol_req_o     (pol_req),
        .layers_met_o  (layers_met),
        .sya_cfg_vld_o (sya_cfg_vld_o),
        .sya_cfg_o     (sya_cfg_o),
        .pol_cfg_vld_o (pol_cfg_vld_o),
        .pol_cfg_o     (pol_cfg_o)
    );

endmodule

/* design/isa_tag_fifo.sv */
// Tag FIFO for outstanding instruction reads
`timescale 1ns/1ps

module isa_tag_fifo #(
    parameter int ISA_FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push_i,
    input  ccu_pkg::isa_addr_t push_addr_i,
    input  logic               pop_i,
    output ccu_pkg::isa_addr_t pop_addr_o,
    output logic               full_o,
    output logic               empty_o
);
    import ccu_pkg::*;

    localparam int PTR_W = (ISA_FIFO_DEPTH > 1) ? $clog2(ISA_FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(ISA_FIFO_DEPTH + 1);

    isa_addr_t        mem [ISA_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;

    // Pointer wrap that also covers non power of two depths
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(ISA_FIFO_DEPTH - 1)) return '0;
        return p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push_i) mem[wr_ptr_q] <= push_addr_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop_i)  rd_ptr_q <= ptr_inc(rd_ptr_q);
            cnt_q <= cnt_q + CNT_W'(push_i) - CNT_W'(pop_i);
        end
    end

    assign pop_addr_o = mem[rd_ptr_q];
    assign full_o     = (cnt_q == CNT_W'(ISA_FIFO_DEPTH));
    assign empty_o    = (cnt_q == '0);

endmodule

/* fetch/isa_fetch.sv */
// Instruction fetch and control FSM
`timescale 1ns/1ps

module isa_fetch (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_i,
    input  logic               isa_rd_addr_rdy_i,
    input  logic               fifo_full_i,
    input  logic               fifo_empty_i,
    input  logic               ccu_req_i,
    input  logic               sya_req_i,
    input  logic               pol_req_i,
    input  logic               op_done_i,
    input  ccu_pkg::isa_addr_t next_addr_i,
    input  logic               layers_met_i,
    output ccu_pkg::isa_addr_t isa_rd_addr_o,
    output logic               isa_rd_addr_vld_o,
    output logic               push_o,
    output logic               op_start_o,
    output ccu_pkg::req_idx_t  grant_o,
    output logic               idle_o,
    output logic               net_fnh_o,
    output ccu_pkg::isa_addr_t isa_min_addr_o
);
    import ccu_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT,
        S_CFG,
        S_DRAIN,
        S_FINISH
    } state_t;

    state_t             state_q, state_d;
    logic [NUM_REQ-1:0] req;
    req_idx_t           pick;
    req_idx_t           grant_q;
    isa_addr_t          ptr_q [NUM_REQ];
    isa_addr_t          ptr_d [NUM_REQ];
    isa_addr_t          min_d;
    isa_addr_t          min_q;
    logic               addr_xfer;

    // ====================
    // Grant
    // ====================
    assign req = {pol_req_i, sya_req_i, ccu_req_i};

    always_comb begin
        pick = '0;
        for (int i = NUM_REQ - 1; i >= 0; i--) begin
            if (req[i]) pick = req_idx_t'(i);   // Lowest index wins
        end
    end

    assign op_start_o = (state_q == S_WAIT) && !layers_met_i && (|req);

    // ====================
    // FSM
    // ====================
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:   if (start_i) state_d = S_WAIT;
            S_WAIT: begin
                if (layers_met_i)  state_d = S_FINISH;
                else if (|req)     state_d = S_CFG;
            end
            S_CFG:    if (op_done_i) state_d = S_DRAIN;
            S_DRAIN:  if (fifo_empty_i) state_d = S_WAIT;   // Overfetched words gone
            S_FINISH: state_d = S_IDLE;
            default:  state_d = S_IDLE;
        endcase
    end

    // ====================
    // Address issue
    // ====================
    // Withdrawn as soon as the configuration closes
    assign isa_rd_addr_vld_o = (state_q == S_CFG) && !fifo_full_i && !op_done_i;
    assign isa_rd_addr_o     = ptr_q[grant_q];
    assign addr_xfer         = isa_rd_addr_vld_o && isa_rd_addr_rdy_i;
    assign push_o            = addr_xfer;

    always_comb begin
        for (int i = 0; i < NUM_REQ; i++) ptr_d[i] = ptr_q[i];
        if (state_q == S_IDLE) begin
            for (int i = 0; i < NUM_REQ; i++) ptr_d[i] = '0;
        end else if (op_done_i) begin
            ptr_d[grant_q] = next_addr_i;           // Resume after last matching word
        end else if (addr_xfer) begin
            ptr_d[grant_q] = ptr_q[grant_q] + 1'b1;
        end
    end

    // Lowest live pointer, tracks the next pointer values
    always_comb begin
        min_d = ptr_d[0];
        for (int i = 1; i < NUM_REQ; i++) begin
            if (ptr_d[i] < min_d) min_d = ptr_d[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            grant_q <= '0;
            min_q   <= '0;
            for (int i = 0; i < NUM_REQ; i++) ptr_q[i] <= '0;
        end else begin
            state_q <= state_d;
            if (op_start_o) grant_q <= pick;
            min_q   <= min_d;
            for (int i = 0; i < NUM_REQ; i++) ptr_q[i] <= ptr_d[i];
        end
    end

    assign grant_o        = grant_q;
    assign idle_o         = (state_q == S_IDLE);
    assign net_fnh_o      = (state_q == S_FINISH);
    assign isa_min_addr_o = min_q;

endmodule

/* list.f */
common/ccu_pkg.sv
design/isa_tag_fifo.sv
fetch/isa_fetch.sv
decode/isa_decode.sv
design/ccu_top.sv
tests/tb_isa_ram.sv
tests/tb_ccu.sv

/* run.sh */
#!/bin/sh
# Build and run the CCU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_ccu -o sim_ccu
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_ccu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* tests/tb_ccu.sv */
// Configuration control unit testbench
`timescale 1ns/1ps

module tb_ccu;
    import ccu_pkg::*;

    localparam int POOL_CORE      = 2;
    localparam int IMG_WORDS      = 64;
    localparam int RUNS           = 2;
    localparam int RUN_CYCLES     = 10000;     // Far above one run under stalls
    localparam int TIMEOUT_CYCLES = RUNS * RUN_CYCLES;

    typedef pol_core_cfg_t [POOL_CORE-1:0] pol_rec_t;

    logic      clk, rst_n, start_i, sya_rdy, pol_rdy;
    logic      net_fnh, addr_vld, addr_rdy, dat_vld, dat_rdy;
    logic      sya_rst, sya_vld, pol_rst, pol_vld;
    isa_addr_t rd_addr, min_addr;
    isa_word_t rd_dat;
    sya_cfg_t  sya_cfg, held_sya;
    pol_rec_t  pol_cfg, held_pol;

    isa_word_t img [IMG_WORDS];
    int        mptr [NUM_REQ];                 // Model read pointers
    int        layers, errors, cycles, sya_recs, pol_recs, hs_cnt, fnh_cnt;
    int        inflight;                       // Reads issued and not yet returned
    logic      pre_start, fnh_seen;
    logic      prev_sya_vld, prev_sya_rdy, prev_pol_vld, prev_pol_rdy, prev_fnh;

    ccu_top #(
        .POOL_CORE (POOL_CORE)
    ) dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_i           (start_i),
        .net_fnh_o         (net_fnh),
        .isa_rd_addr_o     (rd_addr),
        .isa_rd_addr_vld_o (addr_vld),
        .isa_rd_addr_rdy_i (addr_rdy),
        .isa_rd_dat_i      (rd_dat),
        .isa_rd_dat_vld_i  (dat_vld),
        .isa_rd_dat_rdy_o  (dat_rdy),
        .isa_min_addr_o    (min_addr),
        .sya_rst_o         (sya_rst),
        .sya_cfg_vld_o     (sya_vld),
        .sya_cfg_rdy_i     (sya_rdy),
        .sya_cfg_o         (sya_cfg),
        .pol_rst_o         (pol_rst),
        .pol_cfg_vld_o     (pol_vld),
        .pol_cfg_rdy_i     (pol_rdy),
        .pol_cfg_o         (pol_cfg)
    );

    tb_isa_ram #(
        .IMG_WORDS (IMG_WORDS)
    ) u_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .img_i      (img),
        .addr_i     (rd_addr),
        .addr_vld_i (addr_vld),
        .addr_rdy_o (addr_rdy),
        .dat_o      (rd_dat),
        .dat_vld_o  (dat_vld),
        .dat_rdy_i  (dat_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ====================
    // Reference model
    // ====================
    // Image repeats every 64 words, so a scan never runs dry
    function automatic int find_op(input int op, input int from);
        int a;
        a = from;
        for (int n = 0; n < IMG_WORDS; n++) begin
            if (img[a[5:0]][7:0] == 8'(op)) return a;
            a++;
        end
        return -1;
    endfunction

    function automatic sya_cfg_t sya_expect(input isa_word_t w0, input isa_word_t w1);
        sya_cfg_t r;
        r.shift       = w0[15:8];
        r.zp          = w0[23:16];
        r.mode        = w0[25:24];
        r.phase_shift = w0[26];
        r.chn         = w0[38:27];
        r.scale       = w0[58:39];
        r.act_base    = w1[23:8];
        r.wgt_base    = w1[39:24];
        r.ofm_base    = w1[55:40];
        return r;
    endfunction

    function automatic pol_rec_t pol_expect(input isa_word_t w0, input isa_word_t w1);
        pol_rec_t r;
        for (int c = 0; c < POOL_CORE; c++) begin
            r[c].nip   = w0[8 + 16 * c +: 16];    // Point counts with core 0 lowest
            r[c].chn   = w1[8 + 18 * c +: 12];
            r[c].ksize = w1[20 + 18 * c +: 6];
        end
        return r;
    endfunction

    task automatic build_image(input int n_layers);
        isa_word_t w;
        int        op;
        for (int i = 0; i < IMG_WORDS; i++) begin
            for (int k = 0; k < ISA_WIDTH / 32; k++) begin
                w[32 * k +: 32] = $urandom;
            end
            case ($urandom_range(3, 0))
                0:       op = OP_CCU;
                1:       op = OP_SYA;
                2:       op = OP_POL;
                default: op = 5;                  // Foreign opcode
            endcase
            if (i == 3) op = OP_CCU;
            if (i % 8 == 5) op = OP_SYA;          // Eight words make four records
            if (i % 8 == 6) op = OP_POL;
            w[7:0] = 8'(op);
            if (op == OP_CCU) w[8 +: LAYER_WIDTH] = LAYER_WIDTH'(n_layers);
            img[i] = w;
        end
    endtask

    task automatic check_min();
        int m;
        m = mptr[0];
        for (int i = 1; i < NUM_REQ; i++) begin
            if (mptr[i] < m) m = mptr[i];
        end
        assert (min_addr == ADDR_WIDTH'(m))
        else begin
            errors++;
            $display("Error at %0t: min pointer %0d, expected %0d", $time, min_addr, m);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n     = 1'b0;
        pre_start = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    // ====================
    // Monitor
    // ====================
    always @(negedge clk) begin : monitor
        int i0;
        int i1;
        cycles++;
        if (!rst_n || pre_start) begin
            assert (!net_fnh && !addr_vld && !sya_vld && !pol_vld && !dat_rdy &&
                    sya_rst && pol_rst)
            else begin
                errors++;
                $display("Error at %0t: outputs not in reset state before start", $time);
            end
            inflight = 0;
            if (rst_n && start_i) pre_start = 1'b0;
        end else begin
            // Data accepted only while reads are outstanding
            assert (dat_rdy == (inflight != 0))
            else begin
                errors++;
                $display("Error at %0t: data ready %0b with %0d reads in flight",
                         $time, dat_rdy, inflight);
            end
            if (addr_vld && addr_rdy) inflight++;
            if (dat_vld && dat_rdy) inflight--;
            if (sya_vld && !prev_sya_vld) begin
                i0 = find_op(OP_SYA, mptr[OP_SYA]);
                i1 = find_op(OP_SYA, i0 + 1);
                mptr[OP_SYA] = i1 + 1;
                sya_recs++;
                assert (sya_cfg == sya_expect(img[i0[5:0]], img[i1[5:0]]))
                else begin
                    errors++;
                    $display("Error at %0t: systolic record %0d mismatch", $time, sya_recs);
                end
                check_min();
            end
            if (pol_vld && !prev_pol_vld) begin
                i0 = find_op(OP_POL, mptr[OP_POL]);
                i1 = find_op(OP_POL, i0 + 1);
                mptr[OP_POL] = i1 + 1;
                pol_recs++;
                assert (pol_cfg == pol_expect(img[i0[5:0]], img[i1[5:0]]))
                else begin
                    errors++;
                    $display("Error at %0t: pooling record %0d mismatch", $time, pol_recs);
                end
                check_min();
            end
            // Held record while the engine is not ready
            if (prev_sya_vld && !prev_sya_rdy) begin
                assert (sya_vld && sya_cfg == held_sya)
                else begin
                    errors++;
                    $display("Error at %0t: systolic record changed under stall", $time);
                end
            end
            if (prev_pol_vld && !prev_pol_rdy) begin
                assert (pol_vld && pol_cfg == held_pol)
                else begin
                    errors++;
                    $display("Error at %0t: pooling record changed under stall", $time);
                end
            end
            if (sya_vld && sya_rdy) hs_cnt++;
            if (net_fnh) begin
                fnh_cnt++;
                fnh_seen = 1'b1;
                assert (!prev_fnh && hs_cnt == layers)
                else begin
                    errors++;
                    $display("Error at %0t: net finish after %0d of %0d layers",
                             $time, hs_cnt, layers);
                end
            end
            if (prev_fnh) begin
                assert (!net_fnh && sya_rst && pol_rst)
                else begin
                    errors++;
                    $display("Error at %0t: finish pulse or engine resets wrong", $time);
                end
            end
        end
        prev_sya_vld = sya_vld;
        prev_sya_rdy = sya_rdy;
        prev_pol_vld = pol_vld;
        prev_pol_rdy = pol_rdy;
        prev_fnh     = net_fnh;
        held_sya     = sya_cfg;
        held_pol     = pol_cfg;
    end

    // ====================
    // Stimulus
    // ====================
    initial begin : stimulus
        void'($urandom(32'h7cb931dd));
        rst_n        = 1'b0;
        start_i      = 1'b0;
        sya_rdy      = 1'b0;
        pol_rdy      = 1'b0;
        errors       = 0;
        cycles       = 0;
        inflight     = 0;
        pre_start    = 1'b1;
        fnh_seen     = 1'b0;
        prev_sya_vld = 1'b0;
        prev_sya_rdy = 1'b0;
        prev_pol_vld = 1'b0;
        prev_pol_rdy = 1'b0;
        prev_fnh     = 1'b0;
        for (int run = 0; run < RUNS; run++) begin
            layers = 3 + int'($urandom_range(1, 0));
            build_image(layers);
            apply_reset();
            for (int i = 0; i < NUM_REQ; i++) begin
                mptr[i] = 0;
            end
            mptr[OP_CCU] = find_op(OP_CCU, 0) + 1;   // Layer word is always served first
            sya_recs = 0;
            pol_recs = 0;
            hs_cnt   = 0;
            fnh_cnt  = 0;
            fnh_seen = 1'b0;
            @(posedge clk);
            #1 start_i = 1'b1;
            @(posedge clk);
            #1 start_i = 1'b0;
            while (!fnh_seen) begin
                sya_rdy = 1'($urandom_range(1, 0));
                pol_rdy = 1'($urandom_range(1, 0));
                @(posedge clk);
                #1;
            end
            sya_rdy = 1'b0;
            pol_rdy = 1'b0;
            repeat (3) @(posedge clk);
            assert (fnh_cnt == 1 && sya_recs == layers)
            else begin
                errors++;
                $display("Error at %0t: %0d finish pulses, %0d systolic records",
                         $time, fnh_cnt, sya_recs);
            end
            $display("Run %0d: %0d layers, %0d systolic, %0d pooling records, %0d errors",
                     run, layers, sya_recs, pol_recs, errors);
        end
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (cycles >= TIMEOUT_CYCLES);
        $display("Timeout: net finish not reached within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* tests/tb_isa_ram.sv */
// Instruction RAM responder
`timescale 1ns/1ps

module tb_isa_ram #(
    parameter int IMG_WORDS = 64
) (
    input  logic               clk,
    input  logic               rst_n,
    input  ccu_pkg::isa_word_t img_i [IMG_WORDS],
    input  ccu_pkg::isa_addr_t addr_i,
    input  logic               addr_vld_i,
    output logic               addr_rdy_o,
    output ccu_pkg::isa_word_t dat_o,
    output logic               dat_vld_o,
    input  logic               dat_rdy_i
);
    import ccu_pkg::*;

    localparam int AW = $clog2(IMG_WORDS);

    isa_word_t q_dat [$];      // Reads in flight, address order
    int        q_due [$];
    int        now;
    logic      rst_s, a_xfer, d_xfer;
    isa_addr_t a_s;

    initial begin
        addr_rdy_o = 1'b0;
        dat_vld_o  = 1'b0;
        dat_o      = '0;
        now        = 0;
        forever begin
            @(negedge clk);                         // Handshakes settled before the edge
            rst_s  = rst_n;
            a_xfer = addr_vld_i && addr_rdy_o;
            d_xfer = dat_vld_o && dat_rdy_i;
            a_s    = addr_i;
            @(posedge clk);
            #1;
            now++;
            if (!rst_s) begin
                q_dat.delete();
                q_due.delete();
            end else begin
                if (d_xfer) begin
                    void'(q_dat.pop_front());
                    void'(q_due.pop_front());
                end
                if (a_xfer) begin
                    q_dat.push_back(img_i[a_s[AW-1:0]]);   // Image wraps
                    q_due.push_back(now + 1 + int'($urandom_range(2, 0)));
                end
            end
            addr_rdy_o = rst_s && ($urandom_range(3, 0) != 0);   // Stall one cycle in four
            dat_vld_o  = (q_due.size() > 0) && (q_due[0] <= now);
            dat_o      = dat_vld_o ? q_dat[0] : '0;
        end
    end

endmodule
